// ==== logic/opl3_timer_params.svh ====
// shared sizes for the opl3 timer and status subsystem
// host bus widths, timer tick periods and the detection read count

`ifndef OPL3_TIMER_PARAMS_SVH
`define OPL3_TIMER_PARAMS_SVH

`define OPL_DATA_WIDTH    8    // host data bus and register data
`define OPL_ADDR_WIDTH    2    // host address pins a1 a0

`define OPL_TIMER1_TICK   64   // clk_host cycles per timer 1 tick, stands in for 80 us
`define OPL_TIMER2_RATIO  4    // timer 1 ticks per timer 2 tick

`define OPL_DETECT_READS  20   // host reads that force the timer 1 overflow

`endif

// ==== logic/opl3_timer_pkg.sv ====
// shared types for the opl3 timer and status subsystem
// register address enum, register write record, status byte
// and the per timer run state

`include "opl3_timer_params.svh"

package opl3_timer_pkg;

    // register addresses handled here, everything else is ignored
    typedef enum logic [7:0] {
        REG_TIMER1     = 8'h02,    // timer 1 preset
        REG_TIMER2     = 8'h03,    // timer 2 preset
        REG_TIMER_CTRL = 8'h04     // irq reset, masks and start bits
    } opl3_reg_addr_e;

    // one decoded register write from the host port
    typedef struct packed {
        logic                       valid;       // single cycle strobe
        logic                       bank_num;    // from address bit 1 at the index write
        opl3_reg_addr_e             address;     // latched register index
        logic [`OPL_DATA_WIDTH-1:0] data;        // data written to that index
    } opl3_reg_wr_t;

    // status byte as returned on a host read
    typedef struct packed {
        logic       irq;        // bit 7
        logic       t1_flag;    // bit 6
        logic       t2_flag;    // bit 5
        logic [4:0] zero;       // always 0
    } opl3_status_t;

    typedef enum logic {
        TMR_STOPPED = 1'b0,
        TMR_RUNNING = 1'b1
    } opl3_timer_state_e;

endpackage

// ==== logic/host_bus_port.sv ====
// host side of the timer subsystem
// registers the bus pins, turns index/data write pairs into
// register write records and read cycles into single pulses

`timescale 1ns/100ps
`include "opl3_timer_params.svh"

module host_bus_port
    import opl3_timer_pkg::*;
(
    input  logic                       clk_host,
    input  logic                       arst_n,
    input  logic                       cs_n,
    input  logic                       rd_n,
    input  logic                       wr_n,
    input  logic [`OPL_ADDR_WIDTH-1:0] address,
    input  logic [`OPL_DATA_WIDTH-1:0] din,
    output opl3_reg_wr_t               reg_wr,
    output logic                       rd_pulse
);

    logic                       cs_n_q;       // registered pins
    logic                       rd_n_q;
    logic                       wr_n_q;
    logic [`OPL_ADDR_WIDTH-1:0] address_q;
    logic [`OPL_DATA_WIDTH-1:0] din_q;

    logic                       wr_active;    // registered write cycle
    logic                       rd_active;    // registered read cycle
    logic                       rd_prev;      // read level one cycle back

    logic                       wr_valid;
    logic                       wr_bank;
    opl3_reg_addr_e             wr_addr;
    logic [`OPL_DATA_WIDTH-1:0] wr_data;

    // strobes idle high out of reset
    always_ff @(posedge clk_host or negedge arst_n) begin
        if (!arst_n) begin
            cs_n_q <= 1'b1;
            rd_n_q <= 1'b1;
            wr_n_q <= 1'b1;
        end else begin
            cs_n_q <= cs_n;
            rd_n_q <= rd_n;
            wr_n_q <= wr_n;
        end
    end

    always_ff @(posedge clk_host) begin
        address_q <= address;
        din_q     <= din;
    end

    assign wr_active = !cs_n_q && !wr_n_q;
    assign rd_active = !cs_n_q && !rd_n_q;

    // even address = index write, odd address = data write
    always_ff @(posedge clk_host or negedge arst_n) begin
        if (!arst_n) begin
            wr_valid <= 1'b0;
            wr_bank  <= 1'b0;
            wr_addr  <= opl3_reg_addr_e'(0);
        end else begin
            wr_valid <= wr_active && address_q[0];    // one pulse per clock of write
            if (wr_active && !address_q[0]) begin
                wr_bank <= address_q[1];              // a1 selects the bank
                wr_addr <= opl3_reg_addr_e'(din_q);   // any index, unknown ones ignored later
            end
        end
    end

    always_ff @(posedge clk_host) begin
        if (wr_active && address_q[0])
            wr_data <= din_q;                         // payload for the pulse
    end

    always_ff @(posedge clk_host or negedge arst_n) begin
        if (!arst_n)
            rd_prev <= 1'b0;
        else
            rd_prev <= rd_active;
    end

    assign rd_pulse = rd_active && !rd_prev;          // first cycle of a read only

    assign reg_wr = '{valid: wr_valid, bank_num: wr_bank, address: wr_addr, data: wr_data};

endmodule

// ==== logic/sw_detect_trick.sv ====
// software detection helper for timer 1
// counts host reads after timer 1 is started with preset ff
// and forces a timer 1 overflow once enough reads are seen,
// so detection loops built from reads pass on fast hosts

`timescale 1ns/100ps
`include "opl3_timer_params.svh"

module sw_detect_trick
    import opl3_timer_pkg::*;
(
    input  logic         clk_host,
    input  logic         arst_n,
    input  opl3_reg_wr_t reg_wr,
    input  logic         rd_pulse,
    output logic         force_overflow
);

    localparam int unsigned DETECT_READS = `OPL_DETECT_READS;
    localparam int unsigned CNT_W        = $clog2(DETECT_READS);

    logic [`OPL_DATA_WIDTH-1:0] t1_preset;    // local copy of bank 0 reg 02
    logic                       armed;
    logic [CNT_W-1:0]           rd_count;

    logic                       wr_bank0;
    logic                       t1_preset_wr;
    logic                       t1_start_wr;
    logic                       last_read;

    always_comb begin
        wr_bank0     = reg_wr.valid && !reg_wr.bank_num;
        t1_preset_wr = wr_bank0 && reg_wr.address == REG_TIMER1;
        t1_start_wr  = wr_bank0 && reg_wr.address == REG_TIMER_CTRL && reg_wr.data[0];
        last_read    = rd_count == CNT_W'(DETECT_READS - 1);
    end

    always_ff @(posedge clk_host or negedge arst_n) begin
        if (!arst_n) begin
            t1_preset      <= '0;
            armed          <= 1'b0;
            rd_count       <= '0;
            force_overflow <= 1'b0;
        end else begin
            force_overflow <= 1'b0;                    // single cycle pulse

            if (t1_preset_wr)
                t1_preset <= reg_wr.data;

            if (reg_wr.valid) begin
                // a timer 1 start from ff arms, any other write disarms
                armed    <= t1_start_wr && t1_preset == '1;
                rd_count <= '0;
            end else if (armed && rd_pulse) begin
                if (last_read) begin
                    force_overflow <= 1'b1;            // one cycle after the last read
                    armed          <= 1'b0;            // fire once per start
                    rd_count       <= '0;
                end else begin
                    rd_count <= rd_count + 1'b1;
                end
            end
        end
    end

endmodule

// ==== logic/opl3_timers.sv ====
// timer core of the opl3 subsystem
// tick prescaler and divide by ratio for timer 2, two 8 bit
// up counters with preset, mask and run state, the overflow
// flags, and the registered status byte and irq_n output
// Timer index 0 is timer 1 (fine tick), index 1 is timer 2

`timescale 1ns/100ps
`include "opl3_timer_params.svh"

module opl3_timers
    import opl3_timer_pkg::*;
(
    input  logic         clk_host,
    input  logic         arst_n,
    input  opl3_reg_wr_t reg_wr,
    input  logic         force_overflow,
    output opl3_status_t status,
    output logic         irq_n
);

    localparam int unsigned DW          = `OPL_DATA_WIDTH;
    localparam int unsigned TICK_CYCLES = `OPL_TIMER1_TICK;
    localparam int unsigned T2_RATIO    = `OPL_TIMER2_RATIO;
    localparam int unsigned PRESC_W     = $clog2(TICK_CYCLES);
    localparam int unsigned DIV_W       = $clog2(T2_RATIO);

    logic [PRESC_W-1:0]   presc;        // clk_host cycles within a timer 1 tick
    logic [DIV_W-1:0]     t2_div;       // timer 1 ticks within a timer 2 tick
    logic [1:0]           tick;

    logic [1:0][DW-1:0]   preset;
    logic [1:0][DW-1:0]   count;
    opl3_timer_state_e    state [2];
    logic [1:0]           mask;
    logic [1:0]           flag;

    logic                 wr_bank0;
    logic                 ctrl_wr;
    logic                 flag_clr;     // reg 04 with bit 7 set
    logic                 ctrl_set;     // reg 04 without bit 7
    logic [1:0]           preset_wr;
    logic [1:0]           start_req;
    logic [1:0]           ovf;

    always_comb begin
        wr_bank0     = reg_wr.valid && !reg_wr.bank_num;    // timer regs live in bank 0
        ctrl_wr      = wr_bank0 && reg_wr.address == REG_TIMER_CTRL;
        flag_clr     = ctrl_wr && reg_wr.data[7];
        ctrl_set     = ctrl_wr && !reg_wr.data[7];
        preset_wr[0] = wr_bank0 && reg_wr.address == REG_TIMER1;
        preset_wr[1] = wr_bank0 && reg_wr.address == REG_TIMER2;

        tick[0] = presc == PRESC_W'(TICK_CYCLES - 1);
        tick[1] = tick[0] && t2_div == DIV_W'(T2_RATIO - 1);

        for (int i = 0; i < 2; i++) begin
            // start bit 0 for timer 1, bit 1 for timer 2
            start_req[i] = ctrl_set && reg_wr.data[i] && state[i] == TMR_STOPPED;
            ovf[i]       = state[i] == TMR_RUNNING && tick[i] && count[i] == '1;
        end
    end

    // tick generation, restarted by a start so the first tick is a full period
    always_ff @(posedge clk_host or negedge arst_n) begin
        if (!arst_n) begin
            presc  <= '0;
            t2_div <= '0;
        end else begin
            if (start_req[0] || tick[0])
                presc <= '0;
            else
                presc <= presc + 1'b1;

            if (start_req[1] || tick[1])
                t2_div <= '0;
            else if (tick[0])
                t2_div <= t2_div + 1'b1;
        end
    end

    always_ff @(posedge clk_host or negedge arst_n) begin
        if (!arst_n) begin
            preset <= '0;
            count  <= '0;
            mask   <= '0;
            flag   <= '0;
            for (int i = 0; i < 2; i++)
                state[i] <= TMR_STOPPED;
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (preset_wr[i])
                    preset[i] <= reg_wr.data;

                if (ctrl_set) begin
                    mask[i] <= reg_wr.data[6 - i];           // bit 6 masks t1, bit 5 masks t2
                    if (!reg_wr.data[i])
                        state[i] <= TMR_STOPPED;             // cleared start bit stops
                end

                if (start_req[i]) begin
                    state[i] <= TMR_RUNNING;
                    count[i] <= preset[i];                   // start loads the preset
                end else if (ovf[i]) begin
                    count[i] <= preset[i];                   // reload on overflow
                end else if (state[i] == TMR_RUNNING && tick[i]) begin
                    count[i] <= count[i] + 1'b1;
                end

                if (ovf[i] && !mask[i])
                    flag[i] <= 1'b1;
            end

            if (force_overflow && !mask[0])
                flag[0] <= 1'b1;                             // detection trick hits timer 1

            if (flag_clr)
                flag <= '0;                                  // irq reset wins over a new set
        end
    end

    // status byte and irq follow the flags one cycle later
    always_ff @(posedge clk_host or negedge arst_n) begin
        if (!arst_n) begin
            status <= '0;
            irq_n  <= 1'b1;
        end else begin
            status <= '{irq: |flag, t1_flag: flag[0], t2_flag: flag[1], zero: '0};
            irq_n  <= ~|flag;
        end
    end

endmodule

// ==== logic/opl3_timer_top.sv ====
// top level of the opl3 timer and status subsystem
// host bus port, detection helper and timer core

`timescale 1ns/100ps
`include "opl3_timer_params.svh"

module opl3_timer_top
    import opl3_timer_pkg::*;
(
    input  logic                       clk_host,
    input  logic                       arst_n,
    input  logic                       cs_n,
    input  logic                       rd_n,
    input  logic                       wr_n,
    input  logic [`OPL_ADDR_WIDTH-1:0] address,
    input  logic [`OPL_DATA_WIDTH-1:0] din,
    output opl3_status_t               dout,
    output logic                       irq_n
);

    opl3_reg_wr_t reg_wr;            // to both the timers and the detection block
    logic         rd_pulse;          // one per host read
    logic         force_overflow;    // detection forces a timer 1 overflow

    host_bus_port i_host_bus_port (
        .clk_host (clk_host),
        .arst_n   (arst_n),
        .cs_n     (cs_n),
        .rd_n     (rd_n),
        .wr_n     (wr_n),
        .address  (address),
        .din      (din),
        .reg_wr   (reg_wr),
        .rd_pulse (rd_pulse)
    );

    sw_detect_trick i_sw_detect_trick (
        .clk_host       (clk_host),
        .arst_n         (arst_n),
        .reg_wr         (reg_wr),
        .rd_pulse       (rd_pulse),
        .force_overflow (force_overflow)
    );

    opl3_timers i_opl3_timers (
        .clk_host       (clk_host),
        .arst_n         (arst_n),
        .reg_wr         (reg_wr),
        .force_overflow (force_overflow),
        .status         (dout),          // status byte is the read data
        .irq_n          (irq_n)
    );

endmodule

// ==== tb/tb_opl3_timer_top.sv ====
// testbench for the opl3 timer and status subsystem
// clock and reset, host bus tasks, xorshift presets, flag
// reference model, typed compare tasks and the test sequence

`timescale 1ns/100ps
`include "opl3_timer_params.svh"

module tb_opl3_timer_top
    import opl3_timer_pkg::*;
();

    localparam int unsigned TICK         = `OPL_TIMER1_TICK;
    localparam int unsigned T2_TICK      = `OPL_TIMER1_TICK * `OPL_TIMER2_RATIO;
    localparam int unsigned READS        = `OPL_DETECT_READS;
    localparam int unsigned DISARM_READS = `OPL_DETECT_READS + 5;

    logic                       clk_host;
    logic                       arst_n;
    logic                       cs_n;
    logic                       rd_n;
    logic                       wr_n;
    logic [`OPL_ADDR_WIDTH-1:0] address;
    logic [`OPL_DATA_WIDTH-1:0] din;
    opl3_status_t               dout;
    logic                       irq_n;

    logic [31:0] rng_state;        // xorshift state
    logic        exp_t1_flag;      // flags as the register rules predict them
    logic        exp_t2_flag;
    logic        exp_t1_mask;
    logic        exp_t2_mask;
    int unsigned status_errors;
    int unsigned irq_errors;
    int unsigned timeouts;

    opl3_timer_top i_dut (
        .clk_host (clk_host),
        .arst_n   (arst_n),
        .cs_n     (cs_n),
        .rd_n     (rd_n),
        .wr_n     (wr_n),
        .address  (address),
        .din      (din),
        .dout     (dout),
        .irq_n    (irq_n)
    );

    initial begin
        clk_host = 1'b0;
        forever #10 clk_host = ~clk_host;    // 20 ns period
    end

    // inputs change 2 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk_host);
        #2;
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic random_preset(output logic [7:0] preset);
        rng_state = xorshift32(rng_state);
        preset    = 8'hf0 + 8'(rng_state % 15);    // f0 .. fe
    endtask

    // expected status byte built from the tracked flags
    function automatic opl3_status_t expected_status(input logic t1, input logic t2);
        opl3_status_t s;
        s.irq     = t1 | t2;
        s.t1_flag = t1;
        s.t2_flag = t2;
        s.zero    = 5'd0;
        return s;
    endfunction

    task automatic check_status(input opl3_status_t got, input opl3_status_t expected);
        if (got !== expected) begin
            status_errors++;
            $display("[ERROR] %0t: dout expected %02h got %02h", $time, expected, got);
        end
    endtask

    task automatic check_irq(input logic got, input logic expected);
        if (got !== expected) begin
            irq_errors++;
            $display("[ERROR] %0t: irq_n expected %b got %b", $time, expected, got);
        end
    endtask

    // an overflow, real or forced, sets the flag unless masked
    task automatic apply_overflow(input int unsigned timer);
        if (timer == 1 && !exp_t1_mask)
            exp_t1_flag = 1'b1;
        else if (timer == 2 && !exp_t2_mask)
            exp_t2_flag = 1'b1;
    endtask

    task automatic bus_write_cycle(input logic [1:0] a, input logic [7:0] d);
        address = a;
        din     = d;
        cs_n    = 1'b0;
        wr_n    = 1'b0;
        next_cycle();                        // one cycle strobe
        cs_n = 1'b1;
        wr_n = 1'b1;
        repeat (2) next_cycle();
    endtask

    task automatic opl_write(input logic bank, input logic [7:0] addr, input logic [7:0] data);
        bus_write_cycle({bank, 1'b0}, addr);    // index
        bus_write_cycle({bank, 1'b1}, data);    // data
        if (!bank && addr == 8'h04) begin
            if (data[7]) begin
                exp_t1_flag = 1'b0;             // irq reset ignores the other bits
                exp_t2_flag = 1'b0;
            end else begin
                exp_t1_mask = data[6];
                exp_t2_mask = data[5];
            end
        end
    endtask

    task automatic opl_read(output opl3_status_t value);
        cs_n = 1'b0;
        rd_n = 1'b0;
        next_cycle();
        value = dout;                           // status is registered, stable here
        cs_n  = 1'b1;
        rd_n  = 1'b1;
        repeat (2) next_cycle();
    endtask

    task automatic read_and_check();
        opl3_status_t value;
        opl_read(value);
        check_status(value, expected_status(exp_t1_flag, exp_t2_flag));
        check_irq(irq_n, !(exp_t1_flag || exp_t2_flag));
    endtask

    task automatic wait_irq(input logic level, input int unsigned limit,
                            output int unsigned waited);
        waited = 0;
        while (irq_n !== level && waited < limit) begin
            next_cycle();
            waited++;
        end
        if (irq_n !== level) begin
            timeouts++;
            $display("timeout at %0t: irq_n did not reach %b within %0d cycles",
                     $time, level, limit);
        end
    endtask

    // irq_n must stay high for the whole window
    task automatic hold_irq_high(input int unsigned limit);
        for (int unsigned n = 0; n < limit; n++) begin
            if (irq_n !== 1'b1) begin
                check_irq(irq_n, 1'b1);
                break;
            end
            next_cycle();
        end
    endtask

    // stop, clear, preset ff, start timer 1 with timer 2 masked
    task automatic arm_detect();
        opl_write(1'b0, 8'h04, 8'h60);
        opl_write(1'b0, 8'h04, 8'h80);
        opl_write(1'b0, 8'h02, 8'hff);
        opl_write(1'b0, 8'h04, 8'h21);
    endtask

    initial begin : main_sequence
        logic [7:0]  preset;
        int unsigned waited;

        arst_n        = 1'b0;
        cs_n          = 1'b1;
        rd_n          = 1'b1;
        wr_n          = 1'b1;
        address       = '0;
        din           = '0;
        rng_state     = 32'h26b5;
        exp_t1_flag   = 1'b0;
        exp_t2_flag   = 1'b0;
        exp_t1_mask   = 1'b0;
        exp_t2_mask   = 1'b0;
        status_errors = 0;
        irq_errors    = 0;
        timeouts      = 0;

        repeat (3) @(posedge clk_host);
        #2;
        arst_n = 1'b1;
        next_cycle();

        // reset values
        check_status(dout, expected_status(1'b0, 1'b0));
        check_irq(irq_n, 1'b1);

        // timer 1 unmasked from a random preset
        random_preset(preset);
        opl_write(1'b0, 8'h02, preset);
        opl_write(1'b0, 8'h04, 8'h01);
        wait_irq(1'b0, (256 - int'(preset) + 2) * TICK, waited);
        if (waited < (256 - int'(preset) - 1) * TICK) begin
            irq_errors++;
            $display("timer 1 overflowed after %0d cycles, too early for preset %02h",
                     waited, preset);
        end
        apply_overflow(1);
        read_and_check();                                // c0

        // irq reset
        opl_write(1'b0, 8'h04, 8'h80);
        wait_irq(1'b1, 4, waited);
        read_and_check();                                // 00

        // timer 1 masked gives no flag
        opl_write(1'b0, 8'h04, 8'h00);                   // stop both
        opl_write(1'b0, 8'h04, 8'h80);
        random_preset(preset);
        opl_write(1'b0, 8'h02, preset);
        opl_write(1'b0, 8'h04, 8'h41);                   // mask and start timer 1
        hold_irq_high((256 - int'(preset) + 2) * TICK);
        read_and_check();                                // 00

        // timer 2 alongside the masked timer 1
        random_preset(preset);
        opl_write(1'b0, 8'h03, preset);
        opl_write(1'b0, 8'h04, 8'h43);
        wait_irq(1'b0, (256 - int'(preset) + 2) * T2_TICK, waited);
        apply_overflow(2);
        read_and_check();                                // a0
        opl_write(1'b0, 8'h04, 8'h80);
        wait_irq(1'b1, 4, waited);
        read_and_check();

        // detection trick fires on the read after the last counted one
        arm_detect();
        repeat (READS) read_and_check();
        apply_overflow(1);                               // forced
        read_and_check();                                // c0

        // one read short of the count
        arm_detect();
        repeat (READS - 1) read_and_check();
        read_and_check();                                // still 00

        // disarm by a write between reads, timer 1 kept far from a real overflow
        opl_write(1'b0, 8'h04, 8'h60);
        opl_write(1'b0, 8'h04, 8'h80);
        opl_write(1'b0, 8'h02, 8'h00);
        opl_write(1'b0, 8'h04, 8'h21);                   // runs from 00, not armed
        opl_write(1'b0, 8'h02, 8'hff);
        opl_write(1'b0, 8'h04, 8'h21);                   // already running, arms only
        repeat (10) read_and_check();
        random_preset(preset);
        opl_write(1'b0, 8'h03, preset);                  // any write disarms
        repeat (DISARM_READS) read_and_check();
        opl_write(1'b0, 8'h04, 8'h60);

        $display("status errors %0d, irq errors %0d, timeouts %0d",
                 status_errors, irq_errors, timeouts);
        if (status_errors == 0 && irq_errors == 0 && timeouts == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== opl3_timer_top.f ====
+incdir+logic
logic/opl3_timer_pkg.sv
logic/host_bus_port.sv
logic/sw_detect_trick.sv
logic/opl3_timers.sv
logic/opl3_timer_top.sv
tb/tb_opl3_timer_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the opl3 timer testbench with verilator and run it
# exits non zero when the build or the run fails, or when the log reports failing checks

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal \
    -f opl3_timer_top.f \
    --top-module tb_opl3_timer_top \
    --Mdir obj_dir -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "verilator build failed, see build.log"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "CHECKS FAILED" sim.log; then
    exit 1
fi
exit 0
